// ==== include/fp_wb_defs.svh ====
`ifndef FP_WB_DEFS_SVH
`define FP_WB_DEFS_SVH

// single precision format
`define FP_EXPO_WIDTH 8
`define FP_FRAC_WIDTH 23
`define FP_FLEN 32

// units sharing the writeback port
`define FP_NUM_UNITS 3

// instruction tag
`define FP_ID_WIDTH 3

// left normalization shift, enough for a 24-bit mantissa
`define FP_SHIFT_WIDTH 5

`endif

// ==== hdl/fp_types_pkg.sv ====
`default_nettype none

`include "fp_wb_defs.svh"

package fp_types_pkg;

    //////////////////////////////
    // word formats
    //////////////////////////////

    typedef struct packed {
        logic sign;
        logic [`FP_EXPO_WIDTH-1:0] expo;
        logic [`FP_FRAC_WIDTH-1:0] frac;
    } fp_fields_t;

    // same 32 bits, seen raw or split into fields
    typedef union packed {
        logic [`FP_FLEN-1:0] bits;
        fp_fields_t fields;
    } fp_word_u;

    //////////////////////////////
    // rounding
    //////////////////////////////

    typedef struct packed {
        logic guard;
        logic round;
        logic sticky;
    } grs_t;

    // encoding follows the frm field of fcsr
    typedef enum logic [2:0] {
        RNE = 3'b000,
        RTZ = 3'b001,
        RDN = 3'b010,
        RUP = 3'b011,
        RMM = 3'b100
    } rounding_mode_t;

    // exception flags, fflags bit order
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

endpackage

`default_nettype wire

// ==== hdl/wb_types_pkg.sv ====
`default_nettype none

`include "fp_wb_defs.svh"

package wb_types_pkg;
    import fp_types_pkg::*;

    typedef logic [`FP_ID_WIDTH-1:0] id_t;

    //////////////////////////////
    // unit side
    //////////////////////////////

    // expo top bit flags exponent overflow, mant includes hidden bit
    typedef struct packed {
        logic done;
        id_t id;
        rounding_mode_t rm;
        logic sign;
        logic [`FP_EXPO_WIDTH:0] expo;
        logic [`FP_FRAC_WIDTH:0] mant;
        grs_t grs;
        logic [`FP_SHIFT_WIDTH-1:0] left_shift_amt;
        logic [`FP_EXPO_WIDTH-1:0] right_shift_amt;
        fflags_t fflags;
    } unit_result_t;

    //////////////////////////////
    // between stages
    //////////////////////////////

    typedef struct packed {
        logic valid;
        id_t id;
        rounding_mode_t rm;
        logic sign;
        logic [`FP_EXPO_WIDTH:0] expo;
        logic [`FP_FRAC_WIDTH:0] mant;
        grs_t grs;
        logic [`FP_SHIFT_WIDTH-1:0] left_shift_amt;
        logic [`FP_EXPO_WIDTH-1:0] right_shift_amt;
        fflags_t fflags;
    } normalize_packet_t;

    typedef struct packed {
        logic sign;
        logic [`FP_EXPO_WIDTH:0] expo;
        logic [`FP_FRAC_WIDTH:0] mant;
        logic roundup;
        fp_word_u result_if_overflow;
        id_t id;
        fflags_t fflags;
    } round_packet_t;

    //////////////////////////////
    // output ports
    //////////////////////////////

    typedef struct packed {
        logic valid;
        id_t id;
        logic [`FP_FLEN-1:0] data;
    } fp_wb_packet_t;

    typedef struct packed {
        logic valid;
        id_t id;
        fflags_t fflags;
    } fflags_wb_t;

endpackage

`default_nettype wire

// ==== hdl/fp_wb_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_wb_defs.svh"

module fp_wb_control
    import wb_types_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire unit_result_t [`FP_NUM_UNITS-1:0] unit_results,
    output logic [`FP_NUM_UNITS-1:0] ack,
    output normalize_packet_t sel_packet,
    output logic valid_s1,
    output logic valid_s2,
    output logic snoop_valid
);

    localparam int SEL_WIDTH = (`FP_NUM_UNITS > 1) ? $clog2(`FP_NUM_UNITS) : 1;

    logic [`FP_NUM_UNITS-1:0] done;
    logic [SEL_WIDTH-1:0] sel;
    logic any_done;
    unit_result_t sel_result;

    //////////////////////////////
    // arbitration
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < `FP_NUM_UNITS; i++) begin
            done[i] = unit_results[i].done;
        end
    end

    // lowest index wins, so scan downwards
    always_comb begin
        sel = '0;
        for (int i = `FP_NUM_UNITS - 1; i >= 0; i--) begin
            if (done[i]) begin
                sel = SEL_WIDTH'(i);
            end
        end
    end

    assign any_done = |done;

    always_comb begin
        ack = '0;
        ack[sel] = any_done;
    end

    // selected unit into the normalize stage
    assign sel_result = unit_results[sel];

    always_comb begin
        sel_packet.valid = any_done;
        sel_packet.id = sel_result.id;
        sel_packet.rm = sel_result.rm;
        sel_packet.sign = sel_result.sign;
        sel_packet.expo = sel_result.expo;
        sel_packet.mant = sel_result.mant;
        sel_packet.grs = sel_result.grs;
        sel_packet.left_shift_amt = sel_result.left_shift_amt;
        sel_packet.right_shift_amt = sel_result.right_shift_amt;
        sel_packet.fflags = sel_result.fflags;
    end

    //////////////////////////////
    // stage valids
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
            snoop_valid <= 1'b0;
        end else begin
            valid_s1 <= any_done;
            valid_s2 <= valid_s1;
            snoop_valid <= valid_s2;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fp_wb_normalize.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_wb_defs.svh"

module fp_wb_normalize
    import fp_types_pkg::*;
    import wb_types_pkg::*;
(
    input  wire logic clk,
    input  wire normalize_packet_t sel_packet,
    output round_packet_t round_pkt
);

    // mantissa with hidden bit, followed by guard, round, sticky
    localparam int EXT_WIDTH = `FP_FRAC_WIDTH + 4;
    localparam int EXP_W = `FP_EXPO_WIDTH + 1;

    normalize_packet_t pkt_r;
    logic [EXT_WIDTH-1:0] ext;
    logic [EXT_WIDTH-1:0] ext_norm;
    logic [EXT_WIDTH-1:0] lost_mask;
    logic [EXP_W-1:0] expo_norm;
    grs_t grs_norm;
    logic lsb;
    logic roundup;
    logic overflow_to_inf;
    fp_word_u result_if_overflow;

    always_ff @(posedge clk) begin
        pkt_r <= sel_packet;
    end

    //////////////////////////////
    // normalization shift
    //////////////////////////////

    assign ext = {pkt_r.mant, pkt_r.grs};

    // bits that fall off the bottom on a right shift
    assign lost_mask = ~({EXT_WIDTH{1'b1}} << pkt_r.right_shift_amt);

    always_comb begin
        ext_norm = ext;
        expo_norm = pkt_r.expo;
        if (pkt_r.left_shift_amt != '0) begin
            ext_norm = ext << pkt_r.left_shift_amt;
            expo_norm = pkt_r.expo - EXP_W'(pkt_r.left_shift_amt);
        end else if (pkt_r.right_shift_amt != '0) begin
            ext_norm = ext >> pkt_r.right_shift_amt;
            ext_norm[0] = ext_norm[0] | (|(ext & lost_mask));
            expo_norm = pkt_r.expo + EXP_W'(pkt_r.right_shift_amt);
        end
    end

    assign grs_norm = ext_norm[2:0];
    assign lsb = ext_norm[3];

    //////////////////////////////
    // roundup decision
    //////////////////////////////

    always_comb begin
        case (pkt_r.rm)
            RNE: roundup = grs_norm.guard & (grs_norm.round | grs_norm.sticky | lsb);
            RTZ: roundup = 1'b0;
            RDN: roundup = pkt_r.sign & (|grs_norm);
            RUP: roundup = ~pkt_r.sign & (|grs_norm);
            RMM: roundup = grs_norm.guard;
            default: roundup = 1'b0;
        endcase
    end

    // infinity when the mode rounds away from zero, else largest finite
    always_comb begin
        case (pkt_r.rm)
            RNE, RMM: overflow_to_inf = 1'b1;
            RUP: overflow_to_inf = ~pkt_r.sign;
            RDN: overflow_to_inf = pkt_r.sign;
            default: overflow_to_inf = 1'b0;
        endcase
        result_if_overflow.fields.sign = pkt_r.sign;
        result_if_overflow.fields.expo = overflow_to_inf ? '1 : {{(`FP_EXPO_WIDTH-1){1'b1}}, 1'b0};
        result_if_overflow.fields.frac = overflow_to_inf ? '0 : '1;
    end

    always_comb begin
        round_pkt.sign = pkt_r.sign;
        round_pkt.expo = expo_norm;
        round_pkt.mant = ext_norm[EXT_WIDTH-1:3];
        round_pkt.roundup = roundup;
        round_pkt.result_if_overflow = result_if_overflow;
        round_pkt.id = pkt_r.id;
        round_pkt.fflags = pkt_r.fflags;
        // invalid results keep their flags as the unit gave them
        round_pkt.fflags.nx = pkt_r.fflags.nx | ((|grs_norm) & ~pkt_r.fflags.nv);
    end

endmodule

`default_nettype wire

// ==== hdl/fp_wb_round.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_wb_defs.svh"

module fp_wb_round
    import fp_types_pkg::*;
    import wb_types_pkg::*;
(
    input  wire logic clk,
    input  wire round_packet_t round_pkt,
    output id_t wb_id,
    output id_t snoop_id,
    output fp_word_u wb_data,
    output fp_word_u snoop_data,
    output fflags_t wb_fflags
);

    localparam int MANT_W = `FP_FRAC_WIDTH + 1;
    localparam int EXP_W = `FP_EXPO_WIDTH + 1;
    localparam int EXPO_MAX = (2 ** `FP_EXPO_WIDTH) - 1;

    round_packet_t pkt_r;
    logic [MANT_W:0] mant_sum;
    logic mant_carry;
    logic [MANT_W-1:0] mant_out;
    logic [EXP_W:0] expo_sum;
    logic expo_overflow;
    logic underflow;

    always_ff @(posedge clk) begin
        pkt_r <= round_pkt;
    end

    //////////////////////////////
    // mantissa increment
    //////////////////////////////

    assign mant_sum = {1'b0, pkt_r.mant} + (MANT_W + 1)'(pkt_r.roundup);
    assign mant_carry = mant_sum[MANT_W];

    // carry out means 1.000..0 x 2, renormalize by one
    assign mant_out = mant_carry ? mant_sum[MANT_W:1] : mant_sum[MANT_W-1:0];
    assign expo_sum = {1'b0, pkt_r.expo} + (EXP_W + 1)'(mant_carry);

    assign expo_overflow = (expo_sum >= (EXP_W + 1)'(EXPO_MAX));

    // hidden bit clear with something left in the fraction
    assign underflow = ~mant_out[MANT_W-1] & (|mant_out[MANT_W-2:0]);

    //////////////////////////////
    // result and flags
    //////////////////////////////

    always_comb begin
        wb_fflags = pkt_r.fflags;
        wb_data.fields.sign = pkt_r.sign;
        wb_data.fields.expo = expo_sum[`FP_EXPO_WIDTH-1:0];
        wb_data.fields.frac = mant_out[`FP_FRAC_WIDTH-1:0];
        if (pkt_r.fflags.nv) begin
            // NaN from the unit, passed through untouched
            wb_data.fields.expo = pkt_r.expo[`FP_EXPO_WIDTH-1:0];
            wb_data.fields.frac = pkt_r.mant[`FP_FRAC_WIDTH-1:0];
        end else begin
            wb_fflags.of = pkt_r.fflags.of | expo_overflow;
            wb_fflags.uf = pkt_r.fflags.uf | underflow;
            wb_fflags.nx = pkt_r.fflags.nx | expo_overflow;
            if (expo_overflow) begin
                wb_data = pkt_r.result_if_overflow;
            end
        end
    end

    assign wb_id = pkt_r.id;

    //////////////////////////////
    // snoop copy for store forwarding
    //////////////////////////////

    always_ff @(posedge clk) begin
        snoop_data <= wb_data;
        snoop_id <= wb_id;
    end

endmodule

`default_nettype wire

// ==== hdl/fp_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_wb_defs.svh"

module fp_writeback
    import fp_types_pkg::*;
    import wb_types_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire unit_result_t [`FP_NUM_UNITS-1:0] unit_results,
    output logic [`FP_NUM_UNITS-1:0] ack,
    output fp_wb_packet_t wb_packet,
    output fflags_wb_t fflags_wb,
    output fp_wb_packet_t wb_snoop
);

    normalize_packet_t sel_packet;
    round_packet_t round_pkt;
    logic valid_s1;
    logic valid_s2;
    logic snoop_valid;
    id_t wb_id;
    id_t snoop_id;
    fp_word_u wb_data;
    fp_word_u snoop_data;
    fflags_t wb_fflags;

    fp_wb_control i_control (
        .clk          (clk),
        .rst          (rst),
        .unit_results (unit_results),
        .ack          (ack),
        .sel_packet   (sel_packet),
        .valid_s1     (valid_s1),
        .valid_s2     (valid_s2),
        .snoop_valid  (snoop_valid)
    );

    fp_wb_normalize i_normalize (
        .clk        (clk),
        .sel_packet (sel_packet),
        .round_pkt  (round_pkt)
    );

    fp_wb_round i_round (
        .clk        (clk),
        .round_pkt  (round_pkt),
        .wb_id      (wb_id),
        .snoop_id   (snoop_id),
        .wb_data    (wb_data),
        .snoop_data (snoop_data),
        .wb_fflags  (wb_fflags)
    );

    // valids come from control, payload from the datapath
    assign wb_packet = '{valid: valid_s2, id: wb_id, data: wb_data.bits};
    assign fflags_wb = '{valid: valid_s2, id: wb_id, fflags: wb_fflags};
    assign wb_snoop = '{valid: snoop_valid, id: snoop_id, data: snoop_data.bits};

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS = 10.0
) (
    output logic clk
);

    // free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== test/fp_writeback_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_wb_defs.svh"

module fp_writeback_assertions
    import wb_types_pkg::*;
(
    input wire logic clk,
    input wire logic rst,
    input wire unit_result_t [`FP_NUM_UNITS-1:0] unit_results,
    input wire logic [`FP_NUM_UNITS-1:0] ack,
    input wire fp_wb_packet_t wb_packet,
    input wire fp_wb_packet_t wb_snoop
);

    logic [`FP_NUM_UNITS-1:0] done;
    logic [`FP_NUM_UNITS-1:0] both_shifts;

    always_comb begin
        for (int i = 0; i < `FP_NUM_UNITS; i++) begin
            done[i] = unit_results[i].done;
            both_shifts[i] = (unit_results[i].left_shift_amt != '0) &&
                             (unit_results[i].right_shift_amt != '0);
        end
    end

    //////////////////////////////
    // arbitration
    //////////////////////////////

    a_ack_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(ack))
        else $error("more than one unit acked in the same cycle");

    a_ack_done: assert property (@(posedge clk) disable iff (rst) (ack & ~done) == '0)
        else $error("ack raised for a unit that is not done");

    a_shift_exclusive: assert property (@(posedge clk) disable iff (rst)
        (ack & both_shifts) == '0)
        else $error("acked unit has both left and right shift amounts set");

    //////////////////////////////
    // snoop timing
    //////////////////////////////

    a_snoop_follows: assert property (@(posedge clk) disable iff (rst)
        wb_snoop.valid == $past(wb_packet.valid))
        else $error("snoop valid does not follow writeback valid by one cycle");

endmodule

`default_nettype wire

// ==== test/fp_writeback_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_wb_defs.svh"

module fp_writeback_tb
    import fp_types_pkg::*;
    import wb_types_pkg::*;
();

    localparam int ACK_TIMEOUT = 20;
    localparam int DRAIN_TIMEOUT = 20;
    localparam int WB_LATENCY = 2;

    // one modeled result, tagged with the cycle of its ack
    typedef struct packed {
        id_t id;
        logic [`FP_FLEN-1:0] data;
        fflags_t fflags;
        int ack_cycle;
    } expect_t;

    logic clk;
    logic rst;
    unit_result_t [`FP_NUM_UNITS-1:0] unit_results;
    logic [`FP_NUM_UNITS-1:0] ack;
    fp_wb_packet_t wb_packet;
    fflags_wb_t fflags_wb;
    fp_wb_packet_t wb_snoop;

    expect_t expected_q[$];
    int ack_order[$];
    int ack_cycles[$];
    fp_wb_packet_t snoop_ref = '0;
    logic [31:0] rng_state;
    int cycle = 0;

    tb_clock_gen #(.PERIOD_NS(10.0)) i_clock (.clk(clk));

    fp_writeback i_fp_writeback (
        .clk          (clk),
        .rst          (rst),
        .unit_results (unit_results),
        .ack          (ack),
        .wb_packet    (wb_packet),
        .fflags_wb    (fflags_wb),
        .wb_snoop     (wb_snoop)
    );

    bind fp_writeback fp_writeback_assertions i_assertions (
        .clk          (clk),
        .rst          (rst),
        .unit_results (unit_results),
        .ack          (ack),
        .wb_packet    (wb_packet),
        .wb_snoop     (wb_snoop)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    //////////////////////////////
    // error reporting
    //////////////////////////////

    task automatic value_error(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic timeout_error(input string msg);
        $display("Timeout at %0t ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopping on timeout");
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic expect_t model_result(input unit_result_t r);
        expect_t e;
        logic [26:0] ext;
        logic sticky;
        logic [24:0] sum;
        logic [23:0] m;
        logic any_grs;
        logic up;
        logic ovf;
        logic to_inf;
        int expo;
        e.id = r.id;
        e.fflags = r.fflags;
        e.ack_cycle = 0;
        // invalid results come back exactly as the unit gave them
        if (r.fflags.nv) begin
            e.data = {r.sign, r.expo[7:0], r.mant[22:0]};
            return e;
        end
        ext = {r.mant, r.grs};
        expo = int'(r.expo);
        if (r.left_shift_amt != 0) begin
            ext = ext << r.left_shift_amt;
            expo = expo - int'(r.left_shift_amt);
        end else if (r.right_shift_amt != 0) begin
            sticky = 1'b0;
            for (int i = 0; i < 27; i++) begin
                if (i < int'(r.right_shift_amt)) begin
                    sticky = sticky | ext[i];
                end
            end
            ext = ext >> r.right_shift_amt;
            ext[0] = ext[0] | sticky;
            expo = expo + int'(r.right_shift_amt);
        end
        any_grs = |ext[2:0];
        case (r.rm)
            RNE: up = ext[2] & (ext[1] | ext[0] | ext[3]);
            RTZ: up = 1'b0;
            RDN: up = r.sign & any_grs;
            RUP: up = ~r.sign & any_grs;
            RMM: up = ext[2];
            default: up = 1'b0;
        endcase
        sum = {1'b0, ext[26:3]} + {24'd0, up};
        if (sum[24]) begin
            m = sum[24:1];
            expo = expo + 1;
        end else begin
            m = sum[23:0];
        end
        ovf = (expo >= 255);
        to_inf = (r.rm == RNE) || (r.rm == RMM) ||
                 (r.rm == RUP && !r.sign) || (r.rm == RDN && r.sign);
        if (ovf) begin
            e.data = to_inf ? {r.sign, 8'hff, 23'h000000} : {r.sign, 8'hfe, 23'h7fffff};
        end else begin
            e.data = {r.sign, expo[7:0], m[22:0]};
        end
        e.fflags.of = r.fflags.of | ovf;
        e.fflags.nx = r.fflags.nx | any_grs | ovf;
        e.fflags.uf = r.fflags.uf | (~m[23] & (|m[22:0]));
        return e;
    endfunction

    function automatic unit_result_t make_result(
        input id_t id,
        input rounding_mode_t rm,
        input logic sign,
        input logic [8:0] expo,
        input logic [23:0] mant,
        input logic [2:0] grs,
        input logic [4:0] left_shift,
        input logic [7:0] right_shift
    );
        unit_result_t r;
        r = '0;
        r.done = 1'b1;
        r.id = id;
        r.rm = rm;
        r.sign = sign;
        r.expo = expo;
        r.mant = mant;
        r.grs = grs;
        r.left_shift_amt = left_shift;
        r.right_shift_amt = right_shift;
        return r;
    endfunction

    //////////////////////////////
    // unit drivers and monitor
    //////////////////////////////

    // each unit holds done until its ack is seen at a rising edge
    task automatic drive_units(
        input unit_result_t [`FP_NUM_UNITS-1:0] results,
        input logic [`FP_NUM_UNITS-1:0] use_mask
    );
        logic [`FP_NUM_UNITS-1:0] pending;
        expect_t item;
        int waited;
        @(posedge clk);
        for (int u = 0; u < `FP_NUM_UNITS; u++) begin
            if (use_mask[u]) begin
                unit_results[u] <= results[u];
            end
        end
        pending = use_mask;
        waited = 0;
        while (pending != '0) begin
            @(negedge clk);
            for (int u = 0; u < `FP_NUM_UNITS; u++) begin
                if (ack[u] && pending[u]) begin
                    item = model_result(results[u]);
                    item.ack_cycle = cycle;
                    expected_q.push_back(item);
                    ack_order.push_back(u);
                    ack_cycles.push_back(cycle);
                    pending[u] = 1'b0;
                end
            end
            waited++;
            if (waited > ACK_TIMEOUT) begin
                timeout_error("a unit held done but was never acked");
            end
            @(posedge clk);
            for (int u = 0; u < `FP_NUM_UNITS; u++) begin
                if (use_mask[u] && !pending[u]) begin
                    unit_results[u].done <= 1'b0;
                end
            end
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (expected_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                timeout_error("writeback results did not all arrive");
            end
        end
        // the snoop copy of the last result still has to go by
        @(negedge clk);
        @(negedge clk);
    endtask

    task automatic check_outputs();
        expect_t item;
        fp_wb_packet_t next_ref;
        next_ref = '0;
        assert (wb_snoop.valid == snoop_ref.valid)
            else value_error($sformatf("snoop valid %0b, expected %0b",
                                       wb_snoop.valid, snoop_ref.valid));
        if (snoop_ref.valid) begin
            assert (wb_snoop.id == snoop_ref.id && wb_snoop.data == snoop_ref.data)
                else value_error($sformatf("snoop id %0d data %h, expected id %0d data %h",
                                           wb_snoop.id, wb_snoop.data,
                                           snoop_ref.id, snoop_ref.data));
        end
        assert (fflags_wb.valid == wb_packet.valid)
            else value_error("fflags valid differs from writeback valid");
        if (wb_packet.valid) begin
            assert (expected_q.size() != 0)
                else value_error("writeback valid with no result outstanding");
            item = expected_q.pop_front();
            assert (cycle - item.ack_cycle == WB_LATENCY)
                else value_error($sformatf("result %0d cycles after ack, expected %0d",
                                           cycle - item.ack_cycle, WB_LATENCY));
            assert (wb_packet.id == item.id && fflags_wb.id == item.id)
                else value_error($sformatf("id %0d, expected %0d", wb_packet.id, item.id));
            assert (wb_packet.data == item.data)
                else value_error($sformatf("id %0d data %h, expected %h",
                                           item.id, wb_packet.data, item.data));
            assert (fflags_wb.fflags == item.fflags)
                else value_error($sformatf("id %0d flags %b, expected %b",
                                           item.id, fflags_wb.fflags, item.fflags));
            next_ref = '{valid: 1'b1, id: item.id, data: item.data};
        end
        snoop_ref = next_ref;
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            check_outputs();
        end
    end

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic run_single(input int unit, input unit_result_t r);
        unit_result_t [`FP_NUM_UNITS-1:0] results;
        logic [`FP_NUM_UNITS-1:0] mask;
        results = '0;
        mask = '0;
        results[unit] = r;
        mask[unit] = 1'b1;
        drive_units(results, mask);
        wait_drained();
    endtask

    task automatic test_reset_state();
        repeat (3) begin
            @(negedge clk);
            assert (ack == '0)
                else value_error($sformatf("ack %b with no unit done", ack));
            assert (!wb_packet.valid && !fflags_wb.valid && !wb_snoop.valid)
                else value_error("output valid high after reset");
        end
    endtask

    task automatic test_left_shift_rne();
        // hidden bit comes back with one left shift, grs stays nonzero
        run_single(1, make_result(3'd1, RNE, 1'b0, 9'd140, 24'h7a5c3d, 3'b011, 5'd1, 8'd0));
    endtask

    task automatic test_rounding_modes();
        rounding_mode_t modes [5] = '{RNE, RTZ, RDN, RUP, RMM};
        logic [31:0] rnd;
        rng_state = xorshift(rng_state);
        rnd = rng_state;
        foreach (modes[i]) begin
            run_single(0, make_result(3'd2, modes[i], rnd[31], 9'd130,
                                      {1'b1, rnd[22:0]}, rnd[25:23], 5'd0, 8'd0));
        end
        // all ones mantissa carries out when rounded up
        foreach (modes[i]) begin
            run_single(2, make_result(3'd3, modes[i], 1'b0, 9'd100,
                                      24'hffffff, 3'b110, 5'd0, 8'd0));
        end
    endtask

    task automatic test_subnormal_and_invalid();
        unit_result_t r;
        run_single(0, make_result(3'd4, RNE, 1'b0, 9'd0, 24'h800013, 3'b001, 5'd0, 8'd5));
        run_single(1, make_result(3'd4, RTZ, 1'b1, 9'd0, 24'h900003, 3'b000, 5'd0, 8'd3));
        r = make_result(3'd5, RNE, 1'b0, 9'd255, 24'hc00001, 3'b101, 5'd0, 8'd0);
        r.fflags.nv = 1'b1;
        run_single(2, r);
    endtask

    task automatic test_overflow();
        rounding_mode_t modes [5] = '{RNE, RTZ, RDN, RUP, RMM};
        logic [31:0] rnd;
        for (int s = 0; s < 2; s++) begin
            foreach (modes[i]) begin
                rng_state = xorshift(rng_state);
                rnd = rng_state;
                run_single(i % `FP_NUM_UNITS,
                           make_result(3'd6, modes[i], s[0], 9'd300,
                                       {1'b1, rnd[22:0]}, rnd[26:24], 5'd0, 8'd0));
            end
        end
    endtask

    task automatic test_priority();
        unit_result_t [`FP_NUM_UNITS-1:0] results;
        logic [31:0] rnd;
        ack_order.delete();
        ack_cycles.delete();
        for (int u = 0; u < `FP_NUM_UNITS; u++) begin
            rng_state = xorshift(rng_state);
            rnd = rng_state;
            results[u] = make_result(id_t'(2 * u + 1), RNE, rnd[31], 9'd120,
                                     {1'b1, rnd[22:0]}, rnd[25:23], 5'd0, 8'd0);
        end
        drive_units(results, '1);
        for (int i = 0; i < `FP_NUM_UNITS; i++) begin
            assert (ack_order[i] == i)
                else value_error($sformatf("ack number %0d went to unit %0d",
                                           i, ack_order[i]));
            if (i > 0) begin
                assert (ack_cycles[i] == ack_cycles[i - 1] + 1)
                    else value_error("acks of waiting units not on consecutive cycles");
            end
        end
        wait_drained();
    endtask

    //////////////////////////////
    // sequence
    //////////////////////////////

    initial begin
        rst <= 1'b1;
        unit_results <= '0;
        rng_state = 32'h7848beef;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        test_reset_state();
        test_left_shift_rne();
        test_rounding_modes();
        test_subnormal_and_invalid();
        test_overflow();
        test_priority();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
hdl/fp_types_pkg.sv
hdl/wb_types_pkg.sv
hdl/fp_wb_control.sv
hdl/fp_wb_normalize.sv
hdl/fp_wb_round.sv
hdl/fp_writeback.sv
test/tb_clock_gen.sv
test/fp_writeback_assertions.sv
test/fp_writeback_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the writeback testbench with Verilator and run it
# the exit status of the simulation is the result

cd "$(dirname "$0")" && \
verilator --binary --timing --assert \
    --top-module fp_writeback_tb \
    -f project.f \
    -o fp_writeback_sim && \
./obj_dir/fp_writeback_sim || {
    echo "simulation did not pass"
    exit 1
}
